//--- logic/tile_pkg.sv
// Compute tile bus definitions
package tile_pkg;

   typedef logic [31:0] adr_t;
   typedef logic [31:0] dat_t;
   typedef logic [3:0]  sel_t;

   localparam int NR_SLAVES  = 3;
   localparam int SLAVE_DM   = 0;
   localparam int SLAVE_BOOT = 1;
   localparam int SLAVE_UART = 2;

   // Address ranges as match width on the top bits and match value
   localparam int                       DM_MATCH_W   = 1;
   localparam logic [DM_MATCH_W-1:0]    DM_MATCH     = 1'b0;       // 0x00000000-0x7fffffff
   localparam int                       BOOT_MATCH_W = 4;
   localparam logic [BOOT_MATCH_W-1:0]  BOOT_MATCH   = 4'hf;       // 0xf0000000-0xffffffff
   localparam int                       UART_MATCH_W = 28;
   localparam logic [UART_MATCH_W-1:0]  UART_MATCH   = 28'h9000000; // 0x90000000-0x9000000f

   localparam logic [3:0] UART_TX_OFS   = 4'h0; // Transmit register
   localparam logic [3:0] UART_STAT_OFS = 4'h4; // Sent byte counter

   localparam int BOOT_WORDS = 8;

   // Small boot stub, jumps into DM after setup
   localparam dat_t BOOT_ROM [BOOT_WORDS] = '{
      32'h18000000,
      32'ha8200000,
      32'h18600000,
      32'ha8630100,
      32'h44001800,
      32'h15000000,
      32'h03ffffff,
      32'h15000000
   };

endpackage

//--- logic/wb_bus_arbiter.sv
// Round-robin bus arbiter
`timescale 1ns/1ps

module wb_bus_arbiter #(
   parameter int NR_MASTERS = 3
) (
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic [NR_MASTERS-1:0]            m_cyc_i,
   input  logic [NR_MASTERS-1:0]            m_stb_i,
   input  logic [NR_MASTERS-1:0]            m_we_i,
   input  tile_pkg::adr_t [NR_MASTERS-1:0]  m_adr_i,
   input  tile_pkg::dat_t [NR_MASTERS-1:0]  m_dat_i,
   input  tile_pkg::sel_t [NR_MASTERS-1:0]  m_sel_i,
   output logic [NR_MASTERS-1:0]            m_ack_o,
   output logic [NR_MASTERS-1:0]            m_err_o,
   output tile_pkg::dat_t                   m_dat_o,
   output logic                             s_cyc_o,
   output logic                             s_stb_o,
   output logic                             s_we_o,
   output tile_pkg::adr_t                   s_adr_o,
   output tile_pkg::dat_t                   s_dat_o,
   output tile_pkg::sel_t                   s_sel_o,
   input  logic                             s_ack_i,
   input  logic                             s_err_i,
   input  tile_pkg::dat_t                   s_dat_i
);

   localparam int OW = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

   logic [OW-1:0] owner_q;
   logic [OW-1:0] next_owner;
   logic          busy_q;

   // Search starts one past the last owner
   always_comb begin : pick
      int  cand;
      logic found;
      next_owner = owner_q;
      found      = 1'b0;
      for (int i = 1; i <= NR_MASTERS; i++) begin
         cand = (int'(owner_q) + i) % NR_MASTERS;
         if (!found && m_cyc_i[cand]) begin
            next_owner = OW'(cand);
            found      = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q  <= 1'b0;
         owner_q <= OW'(NR_MASTERS - 1); // Master 0 wins first
      end else if (!busy_q) begin
         if (|m_cyc_i) begin
            busy_q  <= 1'b1;
            owner_q <= next_owner;
         end
      end else if (!m_cyc_i[owner_q]) begin
         busy_q <= 1'b0; // Owner finished its cycle
      end
   end

   assign s_cyc_o = busy_q & m_cyc_i[owner_q];
   assign s_stb_o = busy_q & m_stb_i[owner_q];
   assign s_we_o  = m_we_i[owner_q];
   assign s_adr_o = m_adr_i[owner_q];
   assign s_dat_o = m_dat_i[owner_q];
   assign s_sel_o = m_sel_i[owner_q];

   // Response only to the owner, read data to all
   always_comb begin
      m_ack_o = '0;
      m_err_o = '0;
      m_ack_o[owner_q] = busy_q & s_ack_i;
      m_err_o[owner_q] = busy_q & s_err_i;
   end

   assign m_dat_o = s_dat_i;

endmodule

//--- logic/wb_bus_decode.sv
// Slave address decoder
`timescale 1ns/1ps

module wb_bus_decode (
   input  logic                                      clk,
   input  logic                                      rst_n_i,
   input  logic                                      s_cyc_i,
   input  logic                                      s_stb_i,
   input  tile_pkg::adr_t                            s_adr_i,
   output logic                                      s_ack_o,
   output logic                                      s_err_o,
   output tile_pkg::dat_t                            s_dat_o,
   output logic [tile_pkg::NR_SLAVES-1:0]            sl_stb_o,
   input  logic [tile_pkg::NR_SLAVES-1:0]            sl_ack_i,
   input  tile_pkg::dat_t [tile_pkg::NR_SLAVES-1:0]  sl_dat_i
);

   import tile_pkg::*;

   logic [NR_SLAVES-1:0] hit;
   logic                 req;
   logic                 err_q;

   assign req = s_cyc_i & s_stb_i;

   // Ranges are disjoint so at most one hit
   always_comb begin
      hit = '0;
      hit[SLAVE_DM]   = (s_adr_i[31 -: DM_MATCH_W] == DM_MATCH);
      hit[SLAVE_BOOT] = (s_adr_i[31 -: BOOT_MATCH_W] == BOOT_MATCH);
      hit[SLAVE_UART] = (s_adr_i[31 -: UART_MATCH_W] == UART_MATCH);
   end

   assign sl_stb_o = hit & {NR_SLAVES{req}};

   // Unmapped access answered here
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & ~(|hit) & ~err_q; // One cycle pulse
      end
   end

   assign s_ack_o = |sl_ack_i;
   assign s_err_o = err_q;

   always_comb begin
      s_dat_o = '0;
      for (int s = 0; s < NR_SLAVES; s++) begin
         if (hit[s]) begin
            s_dat_o = sl_dat_i[s];
         end
      end
   end

endmodule

//--- logic/wb_sram_sp.sv
// Single-port data memory
`timescale 1ns/1ps

module wb_sram_sp #(
   parameter int MEM_WORDS = 256
) (
   input  logic           clk,
   input  logic           rst_n_i,
   input  logic           stb_i,
   input  logic           we_i,
   input  tile_pkg::adr_t adr_i,
   input  tile_pkg::dat_t dat_i,
   input  tile_pkg::sel_t sel_i,
   output logic           ack_o,
   output tile_pkg::dat_t dat_o
);

   import tile_pkg::*;

   localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

   dat_t          mem [MEM_WORDS];
   logic [AW-1:0] idx;
   logic          access;

   assign idx    = adr_i[AW+1:2]; // Word index, wraps at MEM_WORDS
   assign access = stb_i & ~ack_o; // Held strobe after ack is not a new access

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (sel_i[b]) begin
                  mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end
         dat_o <= mem[idx];
      end
   end

endmodule

//--- logic/bootrom.sv
// Boot program ROM
`timescale 1ns/1ps

module bootrom (
   input  logic           clk,
   input  logic           rst_n_i,
   input  logic           stb_i,
   input  tile_pkg::adr_t adr_i,
   output logic           ack_o,
   output tile_pkg::dat_t dat_o
);

   import tile_pkg::*;

   logic access;

   assign access = stb_i & ~ack_o;

   // Writes get the same ack and change nothing
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         dat_o <= BOOT_ROM[adr_i[4:2]]; // Table repeats every 8 words
      end
   end

endmodule

//--- logic/uart_tx_reg.sv
// UART transmit register block
`timescale 1ns/1ps

module uart_tx_reg (
   input  logic           clk,
   input  logic           rst_n_i,
   input  logic           stb_i,
   input  logic           we_i,
   input  tile_pkg::adr_t adr_i,
   input  tile_pkg::dat_t dat_i,
   output logic           ack_o,
   output tile_pkg::dat_t dat_o,
   output logic [7:0]     tx_data_o,
   output logic           tx_valid_o,
   output logic           irq_o
);

   import tile_pkg::*;

   logic       access;
   logic [7:0] sent_q;

   assign access = stb_i & ~ack_o;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o      <= 1'b0;
         tx_valid_o <= 1'b0;
         sent_q     <= '0;
         irq_o      <= 1'b0;
      end else begin
         ack_o      <= access;
         tx_valid_o <= access & we_i & (adr_i[3:0] == UART_TX_OFS); // Aligned with ack
         if (access && we_i && adr_i[3:0] == UART_TX_OFS) begin
            sent_q <= sent_q + 8'd1;
            irq_o  <= 1'b1;
         end else if (access && !we_i && adr_i[3:0] == UART_STAT_OFS) begin
            irq_o  <= 1'b0; // Status read acknowledges the interrupt
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         tx_data_o <= dat_i[7:0];
         dat_o     <= (!we_i && adr_i[3:0] == UART_STAT_OFS) ? {24'h0, sent_q} : '0;
      end
   end

endmodule

//--- logic/compute_tile_dm.sv
// Compute tile memory side
`timescale 1ns/1ps

module compute_tile_dm #(
   parameter int NR_MASTERS = 3,
   parameter int MEM_WORDS  = 256
) (
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic [NR_MASTERS-1:0]            m_cyc_i,
   input  logic [NR_MASTERS-1:0]            m_stb_i,
   input  logic [NR_MASTERS-1:0]            m_we_i,
   input  tile_pkg::adr_t [NR_MASTERS-1:0]  m_adr_i,
   input  tile_pkg::dat_t [NR_MASTERS-1:0]  m_dat_i,
   input  tile_pkg::sel_t [NR_MASTERS-1:0]  m_sel_i,
   output logic [NR_MASTERS-1:0]            m_ack_o,
   output logic [NR_MASTERS-1:0]            m_err_o,
   output tile_pkg::dat_t                   m_dat_o,
   output logic [7:0]                       uart_tx_data_o,
   output logic                             uart_tx_valid_o,
   output logic                             irq_o
);

   import tile_pkg::*;

   // Granted request, shared by all slaves
   logic s_cyc, s_stb, s_we, s_ack, s_err;
   adr_t s_adr;
   dat_t s_dat, s_rdat;
   sel_t s_sel;

   logic [NR_SLAVES-1:0] sl_stb;
   logic [NR_SLAVES-1:0] sl_ack;
   dat_t [NR_SLAVES-1:0] sl_dat;

   wb_bus_arbiter #(.NR_MASTERS(NR_MASTERS)) u_arbiter (
      .clk(clk), .rst_n_i(rst_n_i),
      .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i), .m_we_i(m_we_i),
      .m_adr_i(m_adr_i), .m_dat_i(m_dat_i), .m_sel_i(m_sel_i),
      .m_ack_o(m_ack_o), .m_err_o(m_err_o), .m_dat_o(m_dat_o),
      .s_cyc_o(s_cyc), .s_stb_o(s_stb), .s_we_o(s_we),
      .s_adr_o(s_adr), .s_dat_o(s_dat), .s_sel_o(s_sel),
      .s_ack_i(s_ack), .s_err_i(s_err), .s_dat_i(s_rdat));

   wb_bus_decode u_decode (
      .clk(clk), .rst_n_i(rst_n_i),
      .s_cyc_i(s_cyc), .s_stb_i(s_stb), .s_adr_i(s_adr),
      .s_ack_o(s_ack), .s_err_o(s_err), .s_dat_o(s_rdat),
      .sl_stb_o(sl_stb), .sl_ack_i(sl_ack), .sl_dat_i(sl_dat));

   wb_sram_sp #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk(clk), .rst_n_i(rst_n_i),
      .stb_i(sl_stb[SLAVE_DM]), .we_i(s_we), .adr_i(s_adr),
      .dat_i(s_dat), .sel_i(s_sel),
      .ack_o(sl_ack[SLAVE_DM]), .dat_o(sl_dat[SLAVE_DM]));

   bootrom u_bootrom (
      .clk(clk), .rst_n_i(rst_n_i),
      .stb_i(sl_stb[SLAVE_BOOT]), .adr_i(s_adr),
      .ack_o(sl_ack[SLAVE_BOOT]), .dat_o(sl_dat[SLAVE_BOOT]));

   // irq_o was bit 2 of the core 0 IRQ vector
   uart_tx_reg u_uart (
      .clk(clk), .rst_n_i(rst_n_i),
      .stb_i(sl_stb[SLAVE_UART]), .we_i(s_we), .adr_i(s_adr), .dat_i(s_dat),
      .ack_o(sl_ack[SLAVE_UART]), .dat_o(sl_dat[SLAVE_UART]),
      .tx_data_o(uart_tx_data_o), .tx_valid_o(uart_tx_valid_o), .irq_o(irq_o));

endmodule

//--- verification/tb_compute_tile_dm.sv
// Compute tile testbench
`timescale 1ns/1ps

module tb_compute_tile_dm;

   import tile_pkg::*;

   localparam int NM      = 3;
   localparam int TIMEOUT = NM * 4; // Cycles per request, contention included

   logic          clk = 1'b0;
   logic          rst_n_i;
   logic [NM-1:0] m_cyc_i;
   logic [NM-1:0] m_stb_i;
   logic [NM-1:0] m_we_i;
   adr_t [NM-1:0] m_adr_i;
   dat_t [NM-1:0] m_dat_i;
   sel_t [NM-1:0] m_sel_i;
   logic [NM-1:0] m_ack_o;
   logic [NM-1:0] m_err_o;
   dat_t          m_dat_o;
   logic [7:0]    uart_tx_data_o;
   logic          uart_tx_valid_o;
   logic          irq_o;

   dat_t          shadow [256];   // DM reference
   dat_t          exp_dat [NM];
   int            wait_cnt [NM];  // Rising edges since the request
   logic [NM-1:0] pending;
   logic [NM-1:0] chk_rd;
   logic [NM-1:0] exp_err;
   logic [NM-1:0] tx_req;
   logic [NM-1:0] stat_req;
   logic [NM-1:0] chk_lat;
   logic [7:0]    sent_cnt;
   logic          irq_model;
   logic          irq_expect;
   logic          started;        // First request issued
   logic [31:0]   lcg_state = 32'd35;
   int            check_errs = 0;
   int            timeouts = 0;

   compute_tile_dm #(.NR_MASTERS(NM), .MEM_WORDS(256)) u_compute_tile_dm (.*);

   always #20 clk = ~clk;

   always @(posedge clk) begin
      for (int g = 0; g < NM; g++) begin
         wait_cnt[g] <= pending[g] ? wait_cnt[g] + 1 : 0;
      end
   end

   // A TX write ack sets the level, a status read ack clears it
   assign irq_expect = |(m_ack_o & tx_req) ? 1'b1 :
                       (|(m_ack_o & stat_req) ? 1'b0 : irq_model);

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic dat_t merge_bytes(input dat_t old, input dat_t wdat, input sel_t sel);
      dat_t mask;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      return (old & ~mask) | (wdat & mask);
   endfunction

   // Random upper bits alias onto the same DM word
   function automatic adr_t dm_addr(input logic [7:0] idx);
      dat_t hi;
      hi = next_random();
      return {1'b0, hi[20:0], idx, 2'b00};
   endfunction

   task automatic access(input int m, input logic we, input adr_t adr, input dat_t dat,
                         input sel_t sel, input logic lone);
      int         n;
      logic       done;
      logic [7:0] idx;
      idx = adr[9:2];
      @(negedge clk);
      chk_rd[m]   = !we;
      exp_err[m]  = 1'b0;
      tx_req[m]   = 1'b0;
      stat_req[m] = 1'b0;
      chk_lat[m]  = lone;
      exp_dat[m]  = 32'h0;
      if (!adr[31]) begin
         exp_dat[m] = shadow[idx];
         if (we) begin
            shadow[idx] = merge_bytes(shadow[idx], dat, sel);
         end
      end else if (adr[31:28] == 4'hf) begin
         exp_dat[m] = BOOT_ROM[adr[4:2]];
      end else if (adr[31:4] == 28'h9000000) begin
         tx_req[m]   = we && adr[3:0] == UART_TX_OFS;
         stat_req[m] = !we && adr[3:0] == UART_STAT_OFS;
         exp_dat[m]  = we ? dat : (stat_req[m] ? {24'h0, sent_cnt} : 32'h0);
      end else begin
         exp_err[m] = 1'b1; // Unmapped
      end
      started    = 1'b1;
      pending[m] = 1'b1;
      m_cyc_i[m] = 1'b1;
      m_stb_i[m] = 1'b1;
      m_we_i[m]  = we;
      m_adr_i[m] = adr;
      m_dat_i[m] = dat;
      m_sel_i[m] = sel;
      done = 1'b0;
      for (n = 0; n < TIMEOUT && !done; n++) begin
         @(negedge clk);
         done = m_ack_o[m] | m_err_o[m];
      end
      if (!done) begin
         timeouts++;
         $display("Timeout: master %0d got no response to address %h", m, adr);
      end else if (tx_req[m] && m_ack_o[m]) begin
         sent_cnt  = sent_cnt + 8'd1;
         irq_model = 1'b1;
      end else if (stat_req[m] && m_ack_o[m]) begin
         irq_model = 1'b0;
      end
      m_cyc_i[m] = 1'b0;
      m_stb_i[m] = 1'b0;
      pending[m] = 1'b0;
   endtask

   assert property (@(negedge clk) disable iff (!rst_n_i) $onehot0({m_ack_o, m_err_o}))
      else begin
         check_errs++;
         $display("ERR m_ack_o/m_err_o: more than one response, ack %h err %h", m_ack_o, m_err_o);
      end
   assert property (@(negedge clk) disable iff (!rst_n_i) ((m_ack_o | m_err_o) & ~m_cyc_i) == '0)
      else begin
         check_errs++;
         $display("ERR m_ack_o/m_err_o: ack %h err %h with m_cyc_i %h", m_ack_o, m_err_o,
                  $sampled(m_cyc_i));
      end
   assert property (@(negedge clk) disable iff (!rst_n_i)
      !started |-> (m_ack_o == '0 && m_err_o == '0 && !uart_tx_valid_o && !irq_o))
      else begin
         check_errs++;
         $display("ERR idle outputs: ack %h err %h uart_tx_valid_o %h irq_o %h", m_ack_o, m_err_o,
                  uart_tx_valid_o, irq_o);
      end
   assert property (@(negedge clk) disable iff (!rst_n_i) uart_tx_valid_o == |(m_ack_o & tx_req))
      else begin
         check_errs++;
         $display("ERR uart_tx_valid_o: got %h expected %h", uart_tx_valid_o,
                  $sampled(|(m_ack_o & tx_req)));
      end
   assert property (@(negedge clk) disable iff (!rst_n_i) irq_o == irq_expect)
      else begin
         check_errs++;
         $display("ERR irq_o: got %h expected %h", irq_o, $sampled(irq_expect));
      end

   for (genvar g = 0; g < NM; g++) begin : g_master
      logic resp;
      assign resp = m_ack_o[g] | m_err_o[g];
      assert property (@(negedge clk) disable iff (!rst_n_i) resp |-> pending[g])
         else begin
            check_errs++;
            $display("Master %0d got a response with no request outstanding", g);
         end
      assert property (@(negedge clk) disable iff (!rst_n_i) resp |-> m_err_o[g] == exp_err[g])
         else begin
            check_errs++;
            $display("ERR m_err_o[%0d]: got %h expected %h", g, m_err_o[g], $sampled(exp_err[g]));
         end
      assert property (@(negedge clk) disable iff (!rst_n_i)
         (m_ack_o[g] && chk_rd[g]) |-> m_dat_o == exp_dat[g])
         else begin
            check_errs++;
            $display("ERR m_dat_o master %0d: got %h expected %h", g, m_dat_o, exp_dat[g]);
         end
      assert property (@(negedge clk) disable iff (!rst_n_i)
         (m_ack_o[g] && tx_req[g]) |-> uart_tx_data_o == exp_dat[g][7:0])
         else begin
            check_errs++;
            $display("ERR uart_tx_data_o: got %h expected %h", uart_tx_data_o, exp_dat[g][7:0]);
         end
      assert property (@(negedge clk) disable iff (!rst_n_i)
         (resp && chk_lat[g]) |-> wait_cnt[g] == 2)
         else begin
            check_errs++;
            $display("ERR response latency master %0d: got %h expected 2", g, wait_cnt[g]);
         end
   end

   initial begin
      dat_t       r;
      logic [7:0] list [16];
      adr_t       a0;
      adr_t       a1;
      adr_t       a2;
      rst_n_i = 1'b0;
      {m_cyc_i, m_stb_i, m_we_i} = '0;
      m_adr_i = '0;
      m_dat_i = '0;
      m_sel_i = '0;
      {pending, chk_rd, exp_err, tx_req, stat_req, chk_lat} = '0;
      sent_cnt  = 8'h0;
      irq_model = 1'b0;
      started   = 1'b0;
      repeat (3) @(negedge clk);
      rst_n_i = 1'b1;
      repeat (3) @(negedge clk); // Idle bus after reset
      for (int i = 0; i < 16; i++) begin
         r = next_random();
         list[i] = {1'b1, r[6:0]}; // Upper half of DM
         access(i % NM, 1'b1, dm_addr(list[i]), next_random(), 4'hf, 1'b1);
      end
      for (int i = 0; i < 32; i++) begin
         r = next_random();
         access(i % NM, 1'b1, dm_addr(list[r[3:0]]), next_random(), r[7:4], 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         access(i % NM, 1'b0, dm_addr(list[i]), '0, 4'hf, 1'b1);
      end
      for (int k = 0; k < 12; k++) begin
         access(k % NM, 1'b0, 32'hf0000000 | (adr_t'(k) << 2), '0, 4'hf, 1'b1);
      end
      access(0, 1'b1, 32'hf0000008, next_random(), 4'hf, 1'b1);
      for (int k = 0; k < 8; k++) begin
         access(1, 1'b0, 32'hf0000000 | (adr_t'(k) << 2), '0, 4'hf, 1'b1);
      end
      access(1, 1'b0, 32'h90000004, '0, 4'hf, 1'b1);
      for (int i = 0; i < 258; i++) begin
         access(i % NM, 1'b1, 32'h90000000, next_random(), 4'h1, 1'b1);
         if (i == 0) begin
            access(2, 1'b0, 32'h90000004, '0, 4'hf, 1'b1);
         end
      end
      access(0, 1'b0, 32'h90000004, '0, 4'hf, 1'b1); // Counter wrapped
      access(2, 1'b0, 32'h90000008, '0, 4'hf, 1'b1);
      for (int i = 0; i < 12; i++) begin
         r = next_random();
         a0 = (i % 3 == 0) ? (32'h80000000 | (r & 32'h0ffffffc)) :
              (i % 3 == 1) ? ((32'ha0000000 + r % 32'h50000000) & 32'hfffffffc) :
                             (32'h90000010 + (r & 32'h0fffffec));
         access(i % NM, r[31], a0, next_random(), 4'hf, 1'b1);
      end
      for (int i = 0; i < 20; i++) begin
         r = next_random();
         if (i % 2 == 0) begin
            a0 = {22'h0, 1'b0, r[6:0], 2'b00};
            a1 = 32'hf0000000 | {27'h0, r[10:8], 2'b00};
         end else begin
            a1 = (32'ha0000000 + r % 32'h50000000) & 32'hfffffffc;
         end
         a2 = dm_addr(list[r[15:12]]);
         fork
            access(0, i % 2 == 0, a0, next_random(), 4'hf, 1'b0);
            access(1, 1'b0, a1, '0, 4'hf, 1'b0);
            access(2, 1'b0, a2, '0, 4'hf, 1'b0);
         join
      end
      repeat (2) @(negedge clk);
      $display("Check errors: %0d, timeouts: %0d", check_errs, timeouts);
      if (check_errs == 0 && timeouts == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- tb.f
logic/tile_pkg.sv
logic/wb_bus_arbiter.sv
logic/wb_bus_decode.sv
logic/wb_sram_sp.sv
logic/bootrom.sv
logic/uart_tx_reg.sv
logic/compute_tile_dm.sv
verification/tb_compute_tile_dm.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_compute_tile_dm
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert -j 0
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
